// ==== flist.f ====
+incdir+source
source/csc_pkg.sv
source/pixel_dispatch.sv
source/ycbcr_lane.sv
source/pixel_collect.sv
source/csc_array.sv
tests/csc_array_checker.sv
tests/csc_array_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = csc_array_tb
FLIST = flist.f
OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove build products and the log"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then \
		echo "result: FAIL"; exit 1; \
	elif ! grep -q "Testbench passed" $(LOG); then \
		echo "result: FAIL, run ended early"; exit 1; \
	else \
		echo "result: PASS"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/csc_array_tb.sv ====
`timescale 1ns/10ps
`include "csc_params.svh"

module csc_array_tb;
	localparam int TOTAL_SLOTS = `CSC_NUM_LANES * `CSC_LANE_DEPTH;
	localparam int OUT_LIMIT = 8;
	localparam int TOTAL_PIXELS = 24 + 24 + 4 + 64 + TOTAL_SLOTS + OUT_LIMIT;

	logic clock;
	logic reset;
	logic in_valid;
	csc_pkg::pixel_word_t in_pixel;
	csc_pkg::pixel_format_t in_format;
	logic in_credit;
	logic out_credit;
	logic out_valid;
	csc_pkg::rgb_sample_t out_rgb;

	integer seed = 32'h95a48c4b;
	int credits_granted = 0;
	int credits_used = 0;
	int out_granted = 0;
	int sent_count = 0;
	int recv_count = 0;
	int check_total = 0;
	int error_total = 0;
	int test_errors = 0;
	string test_name;
	logic out_enable;
	csc_pkg::rgb_sample_t expect_q[$];
	csc_pkg::rgb_sample_t recv_log[$];

	csc_array dut_i (
		.clock(clock),
		.reset(reset),
		.in_valid(in_valid),
		.in_pixel(in_pixel),
		.in_format(in_format),
		.in_credit(in_credit),
		.out_credit(out_credit),
		.out_valid(out_valid),
		.out_rgb(out_rgb)
	);

	bind pixel_collect csc_array_checker checker_i (
		.clock(clock),
		.reset(reset),
		.res_valid(res_valid),
		.fill_count(fill_count),
		.out_credit(out_credit),
		.out_valid(out_valid),
		.slot_freed(slot_freed)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	function automatic int clamp_range(input int v);
		if (v < `CSC_CLAMP_LO)
			return `CSC_CLAMP_LO;
		if (v > `CSC_CLAMP_HI)
			return `CSC_CLAMP_HI;
		return v;
	endfunction

	function automatic logic [7:0] to_byte(input int sum);
		int v;
		v = sum >>> 11;
		if (v < 0)
			return 8'd0;
		if (v > 255)
			return 8'd255;
		return 8'(v);
	endfunction

	// BT.601 reference on integers
	function automatic csc_pkg::rgb_sample_t expected_rgb(input csc_pkg::pixel_word_t w,
			input csc_pkg::pixel_format_t f);
		int y;
		int cb;
		int cr;
		csc_pkg::rgb_sample_t res;
		if (f == csc_pkg::PIX_COMPACT) begin
			y = int'(w.compact.y);
			cb = int'(w.compact.cb) * 8;
			cr = int'(w.compact.cr) * 8;
		end else begin
			y = int'(w.full.y);
			cb = int'(w.full.cb);
			cr = int'(w.full.cr);
		end
		y = clamp_range(y) - 16;
		cb = clamp_range(cb) - 128;
		cr = clamp_range(cr) - 128;
		res.r = to_byte(`CSC_COEF_Y * y + `CSC_COEF_R_CR * cr);
		res.g = to_byte(`CSC_COEF_Y * y - `CSC_COEF_G_CR * cr - `CSC_COEF_G_CB * cb);
		res.b = to_byte(`CSC_COEF_Y * y + `CSC_COEF_B_CB * cb);
		return res;
	endfunction

	function automatic csc_pkg::pixel_word_t full_word(input int y, input int cb, input int cr);
		csc_pkg::pixel_word_t w;
		w = '0;
		w.full.y = 8'(y);
		w.full.cb = 8'(cb);
		w.full.cr = 8'(cr);
		return w;
	endfunction

	function automatic int rand_between(input int lo, input int hi);
		return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
	endfunction

	// sample outside the legal range, low or high side
	function automatic int rand_outside();
		if ($random(seed) & 1)
			return rand_between(0, `CSC_CLAMP_LO - 1);
		return rand_between(`CSC_CLAMP_HI + 1, 255);
	endfunction

	task automatic check_rgb(input string name, input csc_pkg::rgb_sample_t exp,
			input csc_pkg::rgb_sample_t got);
		check_total++;
		if (got !== exp) begin
			error_total++;
			$display("** Error at %0t: %s expected r=%0d g=%0d b=%0d, got r=%0d g=%0d b=%0d",
				$time, name, exp.r, exp.g, exp.b, got.r, got.g, got.b);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int got);
		check_total++;
		if (got != exp) begin
			error_total++;
			$display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, got);
		end
	endtask

	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	task automatic send_pixel(input csc_pkg::pixel_word_t w, input csc_pkg::pixel_format_t f);
		while (credits_granted == credits_used)
			next_cycle();
		in_valid = 1'b1;
		in_pixel = w;
		in_format = f;
		credits_used++;
		sent_count++;
		expect_q.push_back(expected_rgb(w, f));
		next_cycle();
		in_valid = 1'b0;
	endtask

	task automatic wait_drain();
		while (expect_q.size() != 0)
			next_cycle();
		repeat (4) next_cycle();
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors = error_total;
	endtask

	task automatic end_test();
		if (error_total == test_errors)
			$display("test %s: ok", test_name);
		else
			$display("test %s: FAILED with %0d errors", test_name, error_total - test_errors);
	endtask

	always @(posedge clock) begin
		if (!reset && in_credit)
			credits_granted++;
	end

	// compare each output with the oldest expected result
	always @(posedge clock) begin
		if (!reset && out_valid) begin
			recv_count++;
			recv_log.push_back(out_rgb);
			if (expect_q.size() == 0) begin
				error_total++;
				$display("** Error at %0t: output seen with no pixel outstanding", $time);
			end else begin
				check_rgb("out_rgb", expect_q.pop_front(), out_rgb);
			end
		end
	end

	// downstream keeps at most OUT_LIMIT credits outstanding
	always begin
		@(posedge clock);
		#1;
		out_credit = !reset && out_enable && (out_granted - recv_count < OUT_LIMIT);
		if (out_credit)
			out_granted++;
	end

	initial begin
		repeat (TOTAL_PIXELS * 20 + 1000) @(posedge clock);
		$display("watchdog: run did not finish in time, %0d of %0d outputs seen",
			recv_count, sent_count);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		int sat_base;
		int stall_start;
		int y;
		int cb;
		int cr;
		reset = 1'b1;
		in_valid = 1'b0;
		in_pixel = '0;
		in_format = csc_pkg::PIX_FULL;
		out_credit = 1'b0;
		out_enable = 1'b1;
		repeat (8) @(posedge clock);
		#1;
		reset = 1'b0;

		start_test("initial_credits");
		repeat (TOTAL_SLOTS + 16) next_cycle();
		check_count("in_credit pulses", TOTAL_SLOTS, credits_granted);
		end_test();

		start_test("full_in_range");
		for (int i = 0; i < 24; i++)
			send_pixel(full_word(rand_between(16, 235), rand_between(16, 235),
				rand_between(16, 235)), csc_pkg::PIX_FULL);
		wait_drain();
		end_test();

		start_test("full_clamped");
		for (int i = 0; i < 12; i++) begin
			y = rand_outside();
			cb = rand_outside();
			cr = rand_outside();
			send_pixel(full_word(y, cb, cr), csc_pkg::PIX_FULL);
			send_pixel(full_word(clamp_range(y), clamp_range(cb), clamp_range(cr)),
				csc_pkg::PIX_FULL);
		end
		wait_drain();
		end_test();

		start_test("saturation");
		sat_base = recv_log.size();
		send_pixel(full_word(235, 128, 235), csc_pkg::PIX_FULL);
		send_pixel(full_word(16, 16, 128), csc_pkg::PIX_FULL);
		send_pixel(full_word(235, 235, 16), csc_pkg::PIX_FULL);
		send_pixel(full_word(16, 235, 235), csc_pkg::PIX_FULL);
		wait_drain();
		check_count("out_rgb.r at top", 255, int'(recv_log[sat_base].r));
		check_count("out_rgb.b at bottom", 0, int'(recv_log[sat_base + 1].b));
		end_test();

		start_test("compact_and_mixed");
		for (int i = 0; i < 16; i++)
			send_pixel(24'($random(seed)), csc_pkg::PIX_COMPACT);
		for (int i = 0; i < 48; i++)
			send_pixel(24'($random(seed)), csc_pkg::pixel_format_t'($random(seed) & 1));
		wait_drain();
		end_test();

		start_test("back_pressure");
		out_enable = 1'b0;
		stall_start = recv_count;
		for (int i = 0; i < TOTAL_SLOTS + OUT_LIMIT; i++)
			send_pixel(24'($random(seed)), csc_pkg::pixel_format_t'($random(seed) & 1));
		repeat (40) next_cycle();
		check_count("outputs before stall", OUT_LIMIT, recv_count - stall_start);
		stall_start = recv_count;
		repeat (40) next_cycle();
		check_count("outputs during stall", 0, recv_count - stall_start);
		check_count("upstream credits held", 0, credits_granted - credits_used);
		out_enable = 1'b1;
		wait_drain();
		check_count("total outputs", sent_count, recv_count);
		end_test();

		$display("checks %0d, errors %0d, pixels sent %0d, received %0d",
			check_total, error_total, sent_count, recv_count);
		if (error_total == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// ==== tests/csc_array_checker.sv ====
`timescale 1ns/10ps
`include "csc_params.svh"

module csc_array_checker (
	input logic clock,
	input logic reset,
	input logic [`CSC_NUM_LANES-1:0] res_valid,
	input logic [$clog2(`CSC_LANE_DEPTH + 1)-1:0] fill_count [`CSC_NUM_LANES],
	input logic out_credit,
	input logic out_valid,
	input logic slot_freed
);
	localparam int DEPTH = `CSC_LANE_DEPTH;

	int credits_open;
	int fill_total;

	// credits seen at the port minus sends, never wraps
	always_ff @(posedge clock) begin
		if (reset)
			credits_open <= 0;
		else
			credits_open <= credits_open + int'(out_credit) - int'(out_valid);
	end

	always_comb begin
		fill_total = 0;
		for (int i = 0; i < `CSC_NUM_LANES; i++)
			fill_total += int'(fill_count[i]);
	end

	// a send spends a credit that must already be held
	credit_held_a: assert property (@(posedge clock) disable iff (reset)
		out_valid |-> credits_open > 0)
		else $error("out_valid high while no output credit is held");

	// each freed slot is one result leaving the buffers
	freed_slot_a: assert property (@(posedge clock) disable iff (reset)
		fill_total == $past(fill_total) + $countones($past(res_valid))
			- int'($past(slot_freed)))
		else $error("buffered result count does not match arrivals and freed slots");

	// credit loop keeps every lane buffer from overflowing
	for (genvar i = 0; i < `CSC_NUM_LANES; i++) begin : lane_chk
		no_overflow_a: assert property (@(posedge clock) disable iff (reset)
			res_valid[i] |-> fill_count[i] < DEPTH)
			else $error("lane %0d result arrived at a full buffer", i);
	end

endmodule

// ==== source/csc_array.sv ====
`timescale 1ns/10ps
`include "csc_params.svh"

module csc_array (
	input logic clock,
	input logic reset,
	input logic in_valid,
	input csc_pkg::pixel_word_t in_pixel,
	input csc_pkg::pixel_format_t in_format,
	output logic in_credit,
	input logic out_credit,
	output logic out_valid,
	output csc_pkg::rgb_sample_t out_rgb
);
	logic [`CSC_NUM_LANES-1:0] lane_valid;
	csc_pkg::pixel_word_t lane_pixel;
	csc_pkg::pixel_format_t lane_format;
	logic [`CSC_NUM_LANES-1:0] res_valid;
	csc_pkg::rgb_sample_t [`CSC_NUM_LANES-1:0] res_rgb;
	logic slot_freed;

	pixel_dispatch dispatch_i (
		.clock(clock),
		.reset(reset),
		.in_valid(in_valid),
		.in_pixel(in_pixel),
		.in_format(in_format),
		.slot_freed(slot_freed),
		.in_credit(in_credit),
		.lane_valid(lane_valid),
		.lane_pixel(lane_pixel),
		.lane_format(lane_format)
	);

	// lanes share the pixel bus, one-hot valid picks the taker
	for (genvar g = 0; g < `CSC_NUM_LANES; g++) begin : lane_gen
		ycbcr_lane lane_i (
			.clock(clock),
			.reset(reset),
			.pixel_valid(lane_valid[g]),
			.pixel(lane_pixel),
			.format(lane_format),
			.res_valid(res_valid[g]),
			.res_rgb(res_rgb[g])
		);
	end

	pixel_collect collect_i (
		.clock(clock),
		.reset(reset),
		.res_valid(res_valid),
		.res_rgb(res_rgb),
		.out_credit(out_credit),
		.out_valid(out_valid),
		.out_rgb(out_rgb),
		.slot_freed(slot_freed)
	);

endmodule

// ==== source/pixel_collect.sv ====
`timescale 1ns/10ps
`include "csc_params.svh"

module pixel_collect (
	input logic clock,
	input logic reset,
	input logic [`CSC_NUM_LANES-1:0] res_valid,
	input csc_pkg::rgb_sample_t [`CSC_NUM_LANES-1:0] res_rgb,
	input logic out_credit,
	output logic out_valid,
	output csc_pkg::rgb_sample_t out_rgb,
	output logic slot_freed
);
	localparam int NUM_LANES = `CSC_NUM_LANES;
	localparam int DEPTH = `CSC_LANE_DEPTH;
	localparam int LANE_W = $clog2(NUM_LANES);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int FILL_W = $clog2(DEPTH + 1);
	localparam int CREDIT_W = 8;

	csc_pkg::rgb_sample_t buf_mem [NUM_LANES][DEPTH];
	logic [PTR_W-1:0] wr_ptr [NUM_LANES];
	logic [PTR_W-1:0] rd_ptr [NUM_LANES];
	logic [FILL_W-1:0] fill_count [NUM_LANES];
	logic [LANE_W-1:0] drain_ptr;
	logic [CREDIT_W-1:0] credit_count;
	logic head_ready;

	function automatic logic [PTR_W-1:0] next_slot(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// drain lane waits on an empty head to keep input order
	always_comb begin
		head_ready = (fill_count[drain_ptr] != '0);
		out_valid = head_ready && (credit_count != '0);
		out_rgb = buf_mem[drain_ptr][rd_ptr[drain_ptr]];
	end

	// every send frees one slot upstream
	assign slot_freed = out_valid;

	always_ff @(posedge clock) begin
		for (int i = 0; i < NUM_LANES; i++) begin
			if (res_valid[i])
				buf_mem[i][wr_ptr[i]] <= res_rgb[i];
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_LANES; i++) begin
				wr_ptr[i] <= '0;
				rd_ptr[i] <= '0;
				fill_count[i] <= '0;
			end
		end else begin
			for (int i = 0; i < NUM_LANES; i++) begin
				if (res_valid[i])
					wr_ptr[i] <= next_slot(wr_ptr[i]);
				if (out_valid && drain_ptr == LANE_W'(i))
					rd_ptr[i] <= next_slot(rd_ptr[i]);
				fill_count[i] <= fill_count[i] + FILL_W'(res_valid[i])
					- FILL_W'(out_valid && drain_ptr == LANE_W'(i));
			end
		end
	end

	// same lane order as the dispatcher
	always_ff @(posedge clock) begin
		if (reset)
			drain_ptr <= '0;
		else if (out_valid)
			drain_ptr <= (drain_ptr == LANE_W'(NUM_LANES - 1)) ? '0 : drain_ptr + 1'b1;
	end

	// output credits held from downstream
	always_ff @(posedge clock) begin
		if (reset)
			credit_count <= '0;
		else
			credit_count <= credit_count + CREDIT_W'(out_credit) - CREDIT_W'(out_valid);
	end

endmodule

// ==== source/ycbcr_lane.sv ====
`timescale 1ns/10ps
`include "csc_params.svh"

module ycbcr_lane (
	input logic clock,
	input logic reset,
	input logic pixel_valid,
	input csc_pkg::pixel_word_t pixel,
	input csc_pkg::pixel_format_t format,
	output logic res_valid,
	output csc_pkg::rgb_sample_t res_rgb
);
	logic [7:0] y_raw;
	logic [7:0] cb_raw;
	logic [7:0] cr_raw;
	logic signed [9:0] y_off;
	logic signed [9:0] cb_off;
	logic signed [9:0] cr_off;
	logic signed [23:0] sum_r;
	logic signed [23:0] sum_g;
	logic signed [23:0] sum_b;

	logic s1_valid;
	logic signed [23:0] s1_r;
	logic signed [23:0] s1_g;
	logic signed [23:0] s1_b;

	function automatic logic [7:0] clamp_sample(input logic [7:0] v);
		if (v < `CSC_CLAMP_LO)
			return 8'(`CSC_CLAMP_LO);
		if (v > `CSC_CLAMP_HI)
			return 8'(`CSC_CLAMP_HI);
		return v;
	endfunction

	// scale back down, then limit to one byte
	function automatic logic [7:0] saturate(input logic signed [23:0] sum);
		logic signed [23:0] scaled;
		scaled = sum >>> 11;
		if (scaled < 0)
			return 8'd0;
		if (scaled > 255)
			return 8'd255;
		return scaled[7:0];
	endfunction

	// decode the word by its format
	always_comb begin
		if (format == csc_pkg::PIX_COMPACT) begin
			y_raw = pixel.compact.y;
			// chroma index times 8
			cb_raw = 8'(pixel.compact.cb) * 8'd8;
			cr_raw = 8'(pixel.compact.cr) * 8'd8;
		end else begin
			y_raw = pixel.full.y;
			cb_raw = pixel.full.cb;
			cr_raw = pixel.full.cr;
		end
	end

	// black level and chroma centre removed
	always_comb begin
		y_off = $signed({2'b00, clamp_sample(y_raw)}) - 10'sd16;
		cb_off = $signed({2'b00, clamp_sample(cb_raw)}) - 10'sd128;
		cr_off = $signed({2'b00, clamp_sample(cr_raw)}) - 10'sd128;
	end

	always_comb begin
		sum_r = `CSC_COEF_Y * y_off + `CSC_COEF_R_CR * cr_off;
		sum_g = `CSC_COEF_Y * y_off - `CSC_COEF_G_CR * cr_off - `CSC_COEF_G_CB * cb_off;
		sum_b = `CSC_COEF_Y * y_off + `CSC_COEF_B_CB * cb_off;
	end

	// stage 1: matrix sums
	always_ff @(posedge clock) begin
		if (reset)
			s1_valid <= 1'b0;
		else
			s1_valid <= pixel_valid;
	end

	always_ff @(posedge clock) begin
		if (pixel_valid) begin
			s1_r <= sum_r;
			s1_g <= sum_g;
			s1_b <= sum_b;
		end
	end

	// stage 2: shift and saturate
	always_ff @(posedge clock) begin
		if (reset)
			res_valid <= 1'b0;
		else
			res_valid <= s1_valid;
	end

	always_ff @(posedge clock) begin
		if (s1_valid) begin
			res_rgb.r <= saturate(s1_r);
			res_rgb.g <= saturate(s1_g);
			res_rgb.b <= saturate(s1_b);
		end
	end

endmodule

// ==== source/pixel_dispatch.sv ====
`timescale 1ns/10ps
`include "csc_params.svh"

module pixel_dispatch (
	input logic clock,
	input logic reset,
	input logic in_valid,
	input csc_pkg::pixel_word_t in_pixel,
	input csc_pkg::pixel_format_t in_format,
	input logic slot_freed,
	output logic in_credit,
	output logic [`CSC_NUM_LANES-1:0] lane_valid,
	output csc_pkg::pixel_word_t lane_pixel,
	output csc_pkg::pixel_format_t lane_format
);
	localparam int NUM_LANES = `CSC_NUM_LANES;
	localparam int TOTAL_SLOTS = `CSC_NUM_LANES * `CSC_LANE_DEPTH;
	localparam int CNT_W = $clog2(TOTAL_SLOTS + 1);
	localparam int LANE_W = $clog2(NUM_LANES);

	logic [CNT_W-1:0] init_count;
	logic [CNT_W-1:0] pending;
	logic [LANE_W-1:0] lane_ptr;
	logic grant_init;
	logic grant_free;

	// initial grant runs first, freed slots wait behind it
	always_comb begin
		grant_init = (init_count != CNT_W'(TOTAL_SLOTS));
		grant_free = !grant_init && (pending != '0 || slot_freed);
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			init_count <= '0;
			pending <= '0;
			in_credit <= 1'b0;
		end else begin
			in_credit <= grant_init || grant_free;
			if (grant_init)
				init_count <= init_count + 1'b1;
			pending <= pending + CNT_W'(slot_freed) - CNT_W'(grant_free);
		end
	end

	// round-robin steering, one pixel per lane in turn
	always_ff @(posedge clock) begin
		if (reset) begin
			lane_ptr <= '0;
			lane_valid <= '0;
		end else begin
			lane_valid <= in_valid ? (NUM_LANES'(1) << lane_ptr) : '0;
			if (in_valid)
				lane_ptr <= (lane_ptr == LANE_W'(NUM_LANES - 1)) ? '0 : lane_ptr + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (in_valid) begin
			lane_pixel <= in_pixel;
			lane_format <= in_format;
		end
	end

endmodule

// ==== source/csc_pkg.sv ====
package csc_pkg;

	// format flag sent with each pixel
	typedef enum logic {
		PIX_FULL = 1'b0,
		PIX_COMPACT = 1'b1
	} pixel_format_t;

	// three full 8-bit samples
	typedef struct packed {
		logic [7:0] y;
		logic [7:0] cb;
		logic [7:0] cr;
	} pixel_full_t;

	// 18-bit packed sample, top bits unused
	typedef struct packed {
		logic [5:0] pad;
		logic [7:0] y;
		logic [4:0] cr;
		logic [4:0] cb;
	} pixel_compact_t;

	// one input word, read by format
	typedef union packed {
		pixel_full_t full;
		pixel_compact_t compact;
	} pixel_word_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_sample_t;

endpackage

// ==== source/csc_params.svh ====
`ifndef CSC_PARAMS_SVH
`define CSC_PARAMS_SVH

// lane array size
`define CSC_NUM_LANES 4
// result slots per lane in the collector
`define CSC_LANE_DEPTH 4

// BT.601 matrix, scaled by 2^11
`define CSC_COEF_Y 14'sd2383
`define CSC_COEF_R_CR 14'sd3269
`define CSC_COEF_G_CR 14'sd1665
`define CSC_COEF_G_CB 14'sd803
`define CSC_COEF_B_CB 14'sd4131

// legal video range of the input samples
`define CSC_CLAMP_LO 16
`define CSC_CLAMP_HI 235

`endif
